/* src/rob_consts.svh */
// **********************************************************************
// Sizing for the banked reorder buffer
// Bank count also sets the push and commit width
// Depth is per bank, so the buffer holds ROB_BANKS * ROB_DEPTH entries
// **********************************************************************

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Bank count, log2 and plain
`define ROB_P_BANKS 1
`define ROB_BANKS (1 << `ROB_P_BANKS)

// Slots per bank, log2 and plain
`define ROB_P_DEPTH 3
`define ROB_DEPTH (1 << `ROB_P_DEPTH)

// Writeback ports into the buffer
`define ROB_WB_PORTS 2

// Field widths
`define ROB_PC_W 32
`define ROB_LRF_AW 5
`define ROB_PRF_AW 6
`define ROB_DW 32

`endif

/* src/rob_entry_pkg.sv */
// **********************************************************************
// Types written at dispatch: entry tags and the instruction record
// One lane per bank on the push side
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

package rob_entry_pkg;

   typedef logic [`ROB_P_BANKS-1:0] rob_bank_t;
   typedef logic [`ROB_P_DEPTH-1:0] rob_slot_t;

   // Names one entry in the buffer
   typedef struct packed {
      rob_bank_t bank;
      rob_slot_t slot;
   } rob_tag_t;

   // Dispatched instruction record
   typedef struct packed {
      logic [`ROB_PC_W-1:0]   pc;
      logic [`ROB_LRF_AW-1:0] lrd;
      logic [`ROB_PRF_AW-1:0] prd;
      logic                   prd_we;
   } rob_entry_t;

   // Lane 0 is the oldest
   typedef rob_entry_t [`ROB_BANKS-1:0] rob_lanes_t;

endpackage

`default_nettype wire

/* src/rob_result_pkg.sv */
// **********************************************************************
// Types written back by execution and presented at commit
// Flush target is only meaningful when fls is set
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

package rob_result_pkg;
   import rob_entry_pkg::*;

   typedef struct packed {
      logic                 fls;
      logic                 exc;
      logic [`ROB_DW-1:0]   value;
      logic [`ROB_PC_W-1:0] fls_tgt;
   } rob_result_t;

   // One writeback port
   typedef struct packed {
      logic        valid;
      rob_tag_t    tag;
      rob_result_t res;
   } rob_wb_t;

   typedef struct packed {
      rob_entry_t  entry;
      rob_result_t res;
   } rob_cmt_t;

   // Oldest entry of one bank
   typedef struct packed {
      logic        valid;
      logic        done;
      rob_entry_t  entry;
      rob_result_t res;
   } rob_head_t;

endpackage

`default_nettype wire

/* src/rob_dispatch.sv */
// **********************************************************************
// Dispatch side of the reorder buffer
// Push lanes are taken in program order, lane 0 first
// rob_push_size must not exceed the bank count
// rob_free and rob_ready are combinational from bank state
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

module rob_dispatch
   import rob_entry_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    flush,
   input  logic [`ROB_P_BANKS:0]   rob_push_size,
   input  rob_lanes_t              rob_push,
   input  rob_slot_t               bank_wptr     [`ROB_BANKS],
   input  logic [`ROB_BANKS-1:0]   bank_not_full,
   output logic                    rob_ready,
   output rob_tag_t                rob_free      [`ROB_BANKS],
   output logic [`ROB_BANKS-1:0]   bank_push,
   output rob_entry_t              bank_entry    [`ROB_BANKS]
);

   // Bank that receives the next lane 0
   rob_bank_t tail_q;

   for (genvar b = 0; b < `ROB_BANKS; b++)
   begin : g_lane
      rob_bank_t lane;
      rob_bank_t free_bank;

      // Lane feeding bank b
      assign lane          = rob_bank_t'(b) - tail_q;
      assign bank_push[b]  = ({1'b0, lane} < rob_push_size);
      assign bank_entry[b] = rob_push[lane];

      // Tag that lane b gets on the next push
      assign free_bank   = tail_q + rob_bank_t'(b);
      assign rob_free[b] = '{bank: free_bank, slot: bank_wptr[free_bank]};
   end

   // Every bank can take one more entry
   assign rob_ready = &bank_not_full;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         tail_q <= '0;
      else
         tail_q <= tail_q + rob_push_size[`ROB_P_BANKS-1:0];
   end

   // Issue must hold off while any bank is full
   a_push_ready : assert property (
      @(posedge clk) disable iff (!rst_n)
      (!flush && rob_push_size != '0) |-> rob_ready
   );

endmodule

`default_nettype wire

/* src/rob_bank.sv */
// **********************************************************************
// One bank of the reorder buffer, a first-word-fall-through queue
// Head is valid combinationally once an entry is stored
// Writeback ports whose tag names another bank are ignored here
// Flush drops all entries and tags of the bank
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

module rob_bank
   import rob_entry_pkg::*;
   import rob_result_pkg::*;
#(
   parameter int BANK_ID = 0
)
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       flush,
   input  logic       push,
   input  rob_entry_t entry,
   input  logic       pop,
   input  rob_wb_t    wb       [`ROB_WB_PORTS],
   output rob_slot_t  wptr,
   output logic       not_full,
   output rob_head_t  head
);

   // Pointers carry one extra wrap bit
   logic [`ROB_P_DEPTH:0]     rptr_q;
   logic [`ROB_P_DEPTH:0]     wptr_q;
   rob_slot_t                 raddr;
   rob_slot_t                 waddr;
   logic                      empty;

   // Slot tags
   logic [`ROB_DEPTH-1:0]     done_q;
   logic [`ROB_DEPTH-1:0]     fls_q;
   logic [`ROB_DEPTH-1:0]     exc_q;

   // Payload storage
   rob_entry_t                ent_mem [`ROB_DEPTH];
   logic [`ROB_DW-1:0]        val_mem [`ROB_DEPTH];
   logic [`ROB_PC_W-1:0]      tgt_mem [`ROB_DEPTH];

   logic [`ROB_WB_PORTS-1:0]  wb_hit;
   logic                      wb_dup;

   assign raddr    = rptr_q[`ROB_P_DEPTH-1:0];
   assign waddr    = wptr_q[`ROB_P_DEPTH-1:0];
   assign empty    = (rptr_q == wptr_q);
   assign not_full = !((rptr_q[`ROB_P_DEPTH] != wptr_q[`ROB_P_DEPTH]) && (raddr == waddr));
   assign wptr     = waddr;

   // Ports aimed at this bank
   for (genvar p = 0; p < `ROB_WB_PORTS; p++)
   begin : g_wb_sel
      assign wb_hit[p] = wb[p].valid && (wb[p].tag.bank == rob_bank_t'(BANK_ID));
   end

   always_comb
   begin
      wb_dup = 1'b0;
      for (int i = 0; i < `ROB_WB_PORTS; i++)
         for (int j = i + 1; j < `ROB_WB_PORTS; j++)
            if (wb_hit[i] && wb_hit[j] && (wb[i].tag.slot == wb[j].tag.slot))
               wb_dup = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         rptr_q <= '0;
         wptr_q <= '0;
         done_q <= '0;
         fls_q  <= '0;
         exc_q  <= '0;
      end
      else
      begin
         // New entry starts with clean tags
         if (push)
         begin
            wptr_q        <= wptr_q + 1'b1;
            done_q[waddr] <= 1'b0;
            fls_q[waddr]  <= 1'b0;
            exc_q[waddr]  <= 1'b0;
         end
         if (pop)
            rptr_q <= rptr_q + 1'b1;
         for (int p = 0; p < `ROB_WB_PORTS; p++)
         begin
            if (wb_hit[p])
            begin
               done_q[wb[p].tag.slot] <= 1'b1;
               fls_q[wb[p].tag.slot]  <= wb[p].res.fls;
               exc_q[wb[p].tag.slot]  <= wb[p].res.exc;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         ent_mem[waddr] <= entry;
      for (int p = 0; p < `ROB_WB_PORTS; p++)
      begin
         if (wb_hit[p])
         begin
            val_mem[wb[p].tag.slot] <= wb[p].res.value;
            tgt_mem[wb[p].tag.slot] <= wb[p].res.fls_tgt;
         end
      end
   end

   // Oldest entry, read straight from storage
   assign head = '{
      valid: !empty,
      done:  done_q[raddr],
      entry: ent_mem[raddr],
      res:   '{fls: fls_q[raddr], exc: exc_q[raddr],
               value: val_mem[raddr], fls_tgt: tgt_mem[raddr]}
   };

   a_no_overflow : assert property (
      @(posedge clk) disable iff (!rst_n || flush) push |-> not_full
   );

   a_no_underflow : assert property (
      @(posedge clk) disable iff (!rst_n || flush) pop |-> !empty
   );

   // Execution never finishes one entry twice in a cycle
   a_wb_unique : assert property (
      @(posedge clk) disable iff (!rst_n || flush) !wb_dup
   );

endmodule

`default_nettype wire

/* src/rob_commit.sv */
// **********************************************************************
// Commit side of the reorder buffer
// Lane k shows the head of bank (head + k) mod bank count
// A lane is valid only if it and every older lane are done
// cmt_pop_size must not exceed the number of valid lanes
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

module rob_commit
   import rob_entry_pkg::*;
   import rob_result_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  rob_head_t              bank_head    [`ROB_BANKS],
   input  logic [`ROB_P_BANKS:0]  cmt_pop_size,
   output logic [`ROB_BANKS-1:0]  cmt_valid,
   output rob_cmt_t               cmt          [`ROB_BANKS],
   output logic [`ROB_BANKS-1:0]  bank_pop
);

   // Bank holding the oldest entry
   rob_bank_t             head_q;
   logic [`ROB_BANKS-1:0] ent_ready;

   for (genvar k = 0; k < `ROB_BANKS; k++)
   begin : g_lane
      rob_bank_t src;
      rob_bank_t lane;

      // Bank to lane
      assign src          = head_q + rob_bank_t'(k);
      assign cmt[k]       = '{entry: bank_head[src].entry, res: bank_head[src].res};
      assign ent_ready[k] = bank_head[src].valid && bank_head[src].done;

      // Lane to bank, for the pop strobe of bank k
      assign lane        = rob_bank_t'(k) - head_q;
      assign bank_pop[k] = ({1'b0, lane} < cmt_pop_size);
   end

   // Valid chain keeps commit in order
   always_comb
   begin
      cmt_valid[0] = ent_ready[0];
      for (int k = 1; k < `ROB_BANKS; k++)
         cmt_valid[k] = cmt_valid[k-1] && ent_ready[k];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         head_q <= '0;
      else
         head_q <= head_q + cmt_pop_size[`ROB_P_BANKS-1:0];
   end

   // Core may only retire what the banks report as done
   a_pop_valid : assert property (
      @(posedge clk) disable iff (!rst_n || flush)
      cmt_pop_size <= ($countones(cmt_valid))
   );

endmodule

`default_nettype wire

/* src/rob_top.sv */
// **********************************************************************
// Banked reorder buffer top level
// Writeback is never back-pressured
// Flush in a cycle overrides push, writeback and pop
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

module rob_top
   import rob_entry_pkg::*;
   import rob_result_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  logic [`ROB_P_BANKS:0]  rob_push_size,
   input  rob_lanes_t             rob_push,
   output logic                   rob_ready,
   output rob_tag_t               rob_free     [`ROB_BANKS],
   input  rob_wb_t                wb           [`ROB_WB_PORTS],
   output logic [`ROB_BANKS-1:0]  cmt_valid,
   output rob_cmt_t               cmt          [`ROB_BANKS],
   input  logic [`ROB_P_BANKS:0]  cmt_pop_size
);

   rob_slot_t             bank_wptr     [`ROB_BANKS];
   logic [`ROB_BANKS-1:0] bank_not_full;
   logic [`ROB_BANKS-1:0] bank_push;
   rob_entry_t            bank_entry    [`ROB_BANKS];
   logic [`ROB_BANKS-1:0] bank_pop;
   rob_head_t             bank_head     [`ROB_BANKS];

   rob_dispatch u_dispatch (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .rob_push_size (rob_push_size),
      .rob_push      (rob_push),
      .bank_wptr     (bank_wptr),
      .bank_not_full (bank_not_full),
      .rob_ready     (rob_ready),
      .rob_free      (rob_free),
      .bank_push     (bank_push),
      .bank_entry    (bank_entry)
   );

   for (genvar b = 0; b < `ROB_BANKS; b++)
   begin : g_bank
      rob_bank #(
         .BANK_ID (b)
      ) u_bank (
         .clk      (clk),
         .rst_n    (rst_n),
         .flush    (flush),
         .push     (bank_push[b]),
         .entry    (bank_entry[b]),
         .pop      (bank_pop[b]),
         .wb       (wb),
         .wptr     (bank_wptr[b]),
         .not_full (bank_not_full[b]),
         .head     (bank_head[b])
      );
   end

   rob_commit u_commit (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .bank_head    (bank_head),
      .cmt_pop_size (cmt_pop_size),
      .cmt_valid    (cmt_valid),
      .cmt          (cmt),
      .bank_pop     (bank_pop)
   );

endmodule

`default_nettype wire

/* test/rob_tb.sv */
// **********************************************************************
// Testbench for the banked reorder buffer
// Commands and expected masks come from test/rob_stimulus.txt
// Sequence numbers count pushes since reset or the last flush
// Run from the project root so the stimulus path resolves
// **********************************************************************

`default_nettype none

`include "rob_consts.svh"

module rob_tb
   import rob_entry_pkg::*;
   import rob_result_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 50;

   logic                  clk;
   logic                  rst_n;
   logic                  flush;
   logic [`ROB_P_BANKS:0] rob_push_size;
   rob_lanes_t            rob_push;
   logic                  rob_ready;
   rob_tag_t              rob_free  [`ROB_BANKS];
   rob_wb_t               wb        [`ROB_WB_PORTS];
   logic [`ROB_BANKS-1:0] cmt_valid;
   rob_cmt_t              cmt       [`ROB_BANKS];
   logic [`ROB_P_BANKS:0] cmt_pop_size;

   // Reference model with the oldest entry at the front
   rob_entry_t  mdl_ent [$];
   rob_result_t mdl_res [$];
   rob_tag_t    mdl_tag [$];
   int          mdl_seq [$];
   int          n_push;
   int          n_wb;
   int          errors;
   int          timeouts;
   int          cmd_no;
   logic        abort;

   rob_top u_rob_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .rob_push_size (rob_push_size),
      .rob_push      (rob_push),
      .rob_ready     (rob_ready),
      .rob_free      (rob_free),
      .wb            (wb),
      .cmt_valid     (cmt_valid),
      .cmt           (cmt),
      .cmt_pop_size  (cmt_pop_size)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [127:0] exp,
                              input logic [127:0] act);
      assert (exp === act)
      else
      begin
         errors++;
         $display("[ERROR] cmd %0d %s: expected %0h, actual %0h", cmd_no, what, exp, act);
      end
   endtask

   // Inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Entry n lands in bank n mod 2 at slot (n div 2) mod 8
   function automatic rob_tag_t tag_of(input int n);
      rob_tag_t t;
      t.bank = rob_bank_t'(n % `ROB_BANKS);
      t.slot = rob_slot_t'((n / `ROB_BANKS) % `ROB_DEPTH);
      return t;
   endfunction

   function automatic int index_of(input int seq);
      int idx;
      idx = -1;
      foreach (mdl_seq[i])
         if (mdl_seq[i] == seq)
            idx = i;
      return idx;
   endfunction

   task automatic push_records(input int fd);
      int          cnt;
      int          code;
      int          t;
      logic [31:0] pc;
      logic [31:0] lrd;
      logic [31:0] prd;
      logic [31:0] we;
      rob_entry_t  ent [`ROB_BANKS];
      code = $fscanf(fd, "%d", cnt);
      for (int k = 0; k < cnt; k++)
      begin
         code = $fscanf(fd, "%h %h %h %h", pc, lrd, prd, we);
         ent[k].pc     = pc;
         ent[k].lrd    = lrd[`ROB_LRF_AW-1:0];
         ent[k].prd    = prd[`ROB_PRF_AW-1:0];
         ent[k].prd_we = we[0];
      end
      t = 0;
      while (!rob_ready && t < TIMEOUT)
      begin
         next_cycle();
         t++;
      end
      if (!rob_ready)
      begin
         $display("Timeout: rob_ready stayed low while waiting to push at command %0d", cmd_no);
         timeouts++;
         abort = 1'b1;
         return;
      end
      for (int k = 0; k < cnt; k++)
      begin
         check_value($sformatf("push lane %0d free tag", k), tag_of(n_push + k), rob_free[k]);
         rob_push[k] = ent[k];
         mdl_ent.push_back(ent[k]);
         mdl_res.push_back('0);
         mdl_tag.push_back(tag_of(n_push + k));
         mdl_seq.push_back(n_push + k);
      end
      rob_push_size = cnt[`ROB_P_BANKS:0];
      next_cycle();
      rob_push_size = '0;
      n_push += cnt;
   endtask

   task automatic write_back(input int fd);
      int          seq;
      int          idx;
      int          code;
      int          p;
      logic [31:0] fls;
      logic [31:0] exc;
      logic [31:0] value;
      logic [31:0] tgt;
      rob_result_t r;
      code = $fscanf(fd, "%d %h %h %h %h", seq, fls, exc, value, tgt);
      idx = index_of(seq);
      if (idx < 0)
      begin
         $display("Stimulus writes back sequence %0d, which is not in flight", seq);
         errors++;
         abort = 1'b1;
         return;
      end
      r = '{fls: fls[0], exc: exc[0], value: value, fls_tgt: tgt};
      mdl_res[idx] = r;
      // Alternate ports so both are used
      p = n_wb % `ROB_WB_PORTS;
      wb[p] = '{valid: 1'b1, tag: mdl_tag[idx], res: r};
      n_wb++;
      next_cycle();
      wb[p] = '0;
   endtask

   task automatic commit_lanes(input int fd);
      int          pop;
      int          code;
      int          t;
      logic [31:0] mask;
      code = $fscanf(fd, "%d %h", pop, mask);
      if (pop > mdl_ent.size())
      begin
         $display("Stimulus pops %0d entries but only %0d are in flight", pop, mdl_ent.size());
         errors++;
         abort = 1'b1;
         return;
      end
      t = 0;
      while ($countones(cmt_valid) < pop && t < TIMEOUT)
      begin
         next_cycle();
         t++;
      end
      if ($countones(cmt_valid) < pop)
      begin
         $display("Timeout: fewer than %0d commit lanes became valid at command %0d",
                  pop, cmd_no);
         timeouts++;
         abort = 1'b1;
         return;
      end
      check_value("commit valid mask", mask[`ROB_BANKS-1:0], cmt_valid);
      for (int k = 0; k < pop; k++)
      begin
         check_value($sformatf("commit lane %0d entry", k), mdl_ent[k], cmt[k].entry);
         check_value($sformatf("commit lane %0d result", k), mdl_res[k], cmt[k].res);
      end
      cmt_pop_size = pop[`ROB_P_BANKS:0];
      next_cycle();
      cmt_pop_size = '0;
      repeat (pop)
      begin
         void'(mdl_ent.pop_front());
         void'(mdl_res.pop_front());
         void'(mdl_tag.pop_front());
         void'(mdl_seq.pop_front());
      end
   endtask

   task automatic flush_all();
      rob_tag_t first;
      // Finish the oldest entry so lane 0 is valid going into the flush
      if (mdl_tag.size() > 0)
      begin
         wb[0] = '{valid: 1'b1, tag: mdl_tag[0], res: '0};
         next_cycle();
         wb[0] = '0;
         check_value("pre-flush lane 0 valid", 1'b1, cmt_valid[0]);
      end
      flush = 1'b1;
      next_cycle();
      flush = 1'b0;
      mdl_ent.delete();
      mdl_res.delete();
      mdl_tag.delete();
      mdl_seq.delete();
      n_push = 0;
      first = '0;
      check_value("flush valid mask", '0, cmt_valid);
      check_value("flush ready", 1'b1, rob_ready);
      check_value("flush first free tag", first, rob_free[0]);
   endtask

   initial
   begin
      int               fd;
      int               code;
      logic [31:0]      exp;
      logic [8*8-1:0]   cmd;
      logic [8*160-1:0] rest;
      rst_n         = 1'b0;
      flush         = 1'b0;
      rob_push_size = '0;
      rob_push      = '0;
      cmt_pop_size  = '0;
      for (int p = 0; p < `ROB_WB_PORTS; p++)
         wb[p] = '0;
      errors   = 0;
      timeouts = 0;
      n_push   = 0;
      n_wb     = 0;
      cmd_no   = 0;
      abort    = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("reset valid mask", '0, cmt_valid);
      check_value("reset ready", 1'b1, rob_ready);
      fd = $fopen("test/rob_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file test/rob_stimulus.txt");
         errors++;
      end
      else
      begin
         while (!abort && $fscanf(fd, "%s", cmd) == 1)
         begin
            if (cmd == "#")
               code = $fgets(rest, fd);
            else
            begin
               cmd_no++;
               if (cmd == "push")
                  push_records(fd);
               else if (cmd == "wb")
                  write_back(fd);
               else if (cmd == "commit")
                  commit_lanes(fd);
               else if (cmd == "flush")
                  flush_all();
               else if (cmd == "ready")
               begin
                  code = $fscanf(fd, "%h", exp);
                  check_value("ready level", exp[0], rob_ready);
               end
               else
               begin
                  $display("Unknown stimulus command at command %0d", cmd_no);
                  errors++;
                  abort = 1'b1;
               end
            end
         end
         $fclose(fd);
      end
      $display("Commands run %0d, errors %0d, timeouts %0d", cmd_no, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* test/rob_stimulus.txt */
# push <n> then n records <pc> <lrd> <prd> <we>; wb <seq> <fls> <exc> <value> <tgt>; hex fields
# commit <pop> <mask>; ready <0|1>; flush; seq counts pushes since reset or flush
ready 1
push 2 00001000 01 21 1 00001004 02 22 1
push 1 00001008 03 23 0
commit 0 0
wb 0 0 0 aaaa0000 00000000
commit 0 1
wb 2 0 1 cccc0002 00000000
commit 1 1
commit 0 0
wb 1 1 0 bbbb0001 00002000
commit 2 3
# fill both banks, slot index wraps
push 2 00002000 04 24 1 00002004 05 25 1
push 2 00002008 06 26 1 0000200c 07 27 0
push 2 00002010 08 28 1 00002014 09 29 1
push 2 00002018 0a 2a 1 0000201c 0b 2b 1
push 2 00002020 0c 2c 0 00002024 0d 2d 1
push 2 00002028 0e 2e 1 0000202c 0f 2f 1
push 2 00002030 10 30 1 00002034 11 31 0
push 2 00002038 12 32 1 0000203c 13 33 1
ready 0
wb 3 0 0 dddd0003 00000000
commit 0 1
wb 4 1 1 eeee0004 00004000
commit 2 3
ready 1
push 1 00003000 1f 3f 1
ready 0
flush
ready 1
commit 0 0
push 2 00004000 0a 0a 1 00004004 0b 0b 0
wb 1 0 0 12340001 00000000
commit 0 0
wb 0 0 1 12340000 00000000
commit 2 3
ready 1

/* all.f */
+incdir+src
src/rob_entry_pkg.sv
src/rob_result_pkg.sv
src/rob_dispatch.sv
src/rob_bank.sv
src/rob_commit.sv
src/rob_top.sv
test/rob_tb.sv

/* Makefile */
# Verilator build for the reorder buffer testbench
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
